// File: Makefile
SIM = verilator
TOP = kinematicsTb
FILELIST = armKinematics.f
VFLAGS = --binary --timing --assert -Wno-fatal -j 0
BUILD = obj_dir
BIN = $(BUILD)/V$(TOP)
LOG = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST)) hdl/kin_macros.svh

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	grep -qx "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: armKinematics.f
+incdir+hdl
hdl/kinNumPkg.sv
hdl/kinFlowPkg.sv
hdl/trigTable.sv
hdl/creditFifo.sv
hdl/forwardKinematics.sv
hdl/kinematicsTop.sv
tests/kinematics_properties.sv
tests/kinematicsTb.sv

// File: hdl/creditFifo.sv
`include "kin_macros.svh"

module creditFifo #(
	parameter type payloadT = logic [7:0],
	parameter int depth = `KIN_QDEPTH
) (
	input logic clk,
	input logic rst,
	input logic push,
	input payloadT pushData,
	input logic pop,
	output payloadT popData,
	output logic empty,
	output kinFlowPkg::creditT count,
	output logic credit
);
	import kinFlowPkg::*;

	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;

	payloadT mem [depth];
	logic [ptrW-1:0] rdPtr;
	logic [ptrW-1:0] wrPtr;
	logic full;
	logic doPush;
	logic doPop;

	// depth need not be a power of two, so pointers wrap explicitly
	function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] p);
		if (p == ptrW'(depth - 1))
			return '0;
		return p + 1'b1;
	endfunction

	always_comb
	begin
		empty = (count == '0);
		full = (count == creditT'(depth));
		doPush = push && !full;
		doPop = pop && !empty; // an entry pushed this cycle is visible next cycle
	end

	assign popData = mem[rdPtr]; // head is always presented
	assign credit = doPop; // one credit goes back for every entry that leaves

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10: count <= count + creditT'(1);
				2'b01: count <= count - creditT'(1);
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hdl/forwardKinematics.sv
`include "kin_macros.svh"

module forwardKinematics (
	input logic clk,
	input logic rst,
	input logic inValid,
	input kinNumPkg::angleT th1,
	input kinNumPkg::angleT th2,
	input kinNumPkg::lengthT l1,
	input kinNumPkg::lengthT l2,
	output logic outValid,
	output kinNumPkg::coordT x,
	output kinNumPkg::coordT y
);
	import kinNumPkg::*;

	// |trig| never exceeds 1 << KIN_FRAC, so a product needs one sign bit on top
	localparam int prodW = `KIN_LEN_W + `KIN_FRAC + 1;

	typedef logic signed [prodW-1:0] prodT;

	logic [3:0] validPipe; // one bit per stage
	logic signed [`KIN_ANGLE_W:0] sumTh;

	degT deg1S1;
	degT deg12S1;
	lengthT l1S1;
	lengthT l2S1;
	lengthT l1S2;
	lengthT l2S2;
	trigT sin1;
	trigT cos1;
	trigT sin12;
	trigT cos12;
	prodT l1Cos;
	prodT l1Sin;
	prodT l2Cos;
	prodT l2Sin;

	// the angle sum spans -512 to 510, so it may need two corrections of 360
	function automatic degT normDeg(input logic signed [`KIN_ANGLE_W:0] a);
		logic signed [`KIN_ANGLE_W+1:0] w;
		w = a;
		if (w < -360)
			w = w + 720;
		else if (w < 0)
			w = w + 360;
		else if (w >= 360)
			w = w - 360;
		return degT'(w);
	endfunction

	always_comb
	begin
		sumTh = th1 + th2;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			validPipe <= '0;
		else
			validPipe <= {validPipe[2:0], inValid};
	end

	// stage one folds both angles into a single turn
	always_ff @(posedge clk)
	begin
		deg1S1 <= normDeg(th1);
		deg12S1 <= normDeg(sumTh);
		l1S1 <= l1;
		l2S1 <= l2;
	end

	// stage two is the lookup itself, registered inside the tables
	trigTable trigTh1 (
		.clk(clk),
		.angle(deg1S1),
		.sine(sin1),
		.cosine(cos1)
	);

	trigTable trigTh12 (
		.clk(clk),
		.angle(deg12S1),
		.sine(sin12),
		.cosine(cos12)
	);

	always_ff @(posedge clk)
	begin
		l1S2 <= l1S1; // lengths line up with the table outputs
		l2S2 <= l2S1;
	end

	// stage three, lengths are unsigned so a zero bit goes on top before the multiply
	always_ff @(posedge clk)
	begin
		l1Cos <= $signed({1'b0, l1S2}) * cos1;
		l1Sin <= $signed({1'b0, l1S2}) * sin1;
		l2Cos <= $signed({1'b0, l2S2}) * cos12;
		l2Sin <= $signed({1'b0, l2S2}) * sin12;
	end

	always_ff @(posedge clk)
	begin
		x <= coordT'(l1Cos) + coordT'(l2Cos);
		y <= coordT'(l1Sin) + coordT'(l2Sin);
	end

	assign outValid = validPipe[3];

endmodule

// File: hdl/kinFlowPkg.sv
`include "kin_macros.svh"

package kinFlowPkg;

	typedef struct packed {
		kinNumPkg::angleT th1;
		kinNumPkg::angleT th2;
		kinNumPkg::lengthT l1;
		kinNumPkg::lengthT l2;
	} kinReqT; // 48 bits

	typedef struct packed {
		kinNumPkg::coordT x;
		kinNumPkg::coordT y;
	} kinResT; // 66 bits

	// must hold every value from 0 up to a full queue
	typedef logic [$clog2(`KIN_QDEPTH + 1)-1:0] creditT;

endpackage

// File: hdl/kinNumPkg.sv
`include "kin_macros.svh"

package kinNumPkg;

	// joint angle as delivered with a request, may be negative
	typedef logic signed [`KIN_ANGLE_W-1:0] angleT;

	typedef logic [`KIN_ANGLE_W-1:0] degT; // folded angle, always 0 to 359

	typedef logic [`KIN_LEN_W-1:0] lengthT;

	// fixed point sine or cosine, 1.0 is 1 << KIN_FRAC
	typedef logic signed [`KIN_TRIG_W-1:0] trigT;

	// end point coordinate with KIN_FRAC fraction bits
	typedef logic signed [`KIN_COORD_W-1:0] coordT;

endpackage

// File: hdl/kin_macros.svh
`ifndef KIN_MACROS_SVH
`define KIN_MACROS_SVH

// joint angle in whole degrees, signed
`define KIN_ANGLE_W 9

// link length, unsigned
`define KIN_LEN_W 15

// sine and cosine values are signed Q2.14
`define KIN_TRIG_W 16

`define KIN_FRAC 14 // fraction bits shared by trig values and coordinates

// coordinates carry the same 14 fraction bits as the trig values
`define KIN_COORD_W 33

// entries in each credit queue, also the initial credit count on both sides
`define KIN_QDEPTH 4

`endif

// File: hdl/kinematicsTop.sv
`include "kin_macros.svh"

module kinematicsTop (
	input logic clk,
	input logic rst,
	input logic reqValid,
	input kinNumPkg::angleT th1,
	input kinNumPkg::angleT th2,
	input kinNumPkg::lengthT l1,
	input kinNumPkg::lengthT l2,
	output logic reqCredit,
	output logic resValid,
	output kinNumPkg::coordT x,
	output kinNumPkg::coordT y,
	input logic resCredit
);
	import kinNumPkg::*;
	import kinFlowPkg::*;

	kinReqT reqIn;
	kinReqT reqHead;
	logic reqEmpty;
	creditT reqCount; // watched by the bound assertions
	kinResT resIn;
	kinResT resHead;
	logic resEmpty;
	creditT resCount;
	logic fkValid;
	coordT fkX;
	coordT fkY;
	creditT inFlight;
	creditT outCredits;
	logic [$bits(creditT):0] committed;
	logic issue;
	logic resPop;

	always_comb
	begin
		reqIn.th1 = th1;
		reqIn.th2 = th2;
		reqIn.l1 = l1;
		reqIn.l2 = l2;
		resIn.x = fkX;
		resIn.y = fkY;
		// every issued item must already own a slot in the output queue
		committed = {1'b0, resCount} + {1'b0, inFlight};
		issue = !reqEmpty && (committed < `KIN_QDEPTH);
		resPop = !resEmpty && (outCredits != '0);
		x = resHead.x;
		y = resHead.y;
	end

	creditFifo #(.payloadT(kinReqT), .depth(`KIN_QDEPTH)) reqFifo (
		.clk(clk), .rst(rst),
		.push(reqValid), .pushData(reqIn),
		.pop(issue), .popData(reqHead),
		.empty(reqEmpty), .count(reqCount), .credit(reqCredit)
	);

	forwardKinematics fk (
		.clk(clk), .rst(rst), .inValid(issue),
		.th1(reqHead.th1), .th2(reqHead.th2), .l1(reqHead.l1), .l2(reqHead.l2),
		.outValid(fkValid), .x(fkX), .y(fkY)
	);

	// the pop pulse of the result queue is the result strobe itself
	creditFifo #(.payloadT(kinResT), .depth(`KIN_QDEPTH)) resFifo (
		.clk(clk), .rst(rst),
		.push(fkValid), .pushData(resIn),
		.pop(resPop), .popData(resHead),
		.empty(resEmpty), .count(resCount), .credit(resValid)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			inFlight <= '0;
			outCredits <= creditT'(`KIN_QDEPTH); // receiver starts with an empty queue
		end
		else
		begin
			case ({issue, fkValid})
				2'b10: inFlight <= inFlight + creditT'(1);
				2'b01: inFlight <= inFlight - creditT'(1);
				default: inFlight <= inFlight;
			endcase
			case ({resPop, resCredit})
				2'b10: outCredits <= outCredits - creditT'(1);
				2'b01: outCredits <= outCredits + creditT'(1);
				default: outCredits <= outCredits;
			endcase
		end
	end

endmodule

// File: hdl/sineQuarter.hex
// one 16-bit hex value per line, for 0 to 90 degrees in order
// each value is 16384 * sin(angle) rounded to the nearest integer
0000
011E
023C
0359
0477
0594
06B1
07CD
08E8
0A03
0B1D
0C36
0D4E
0E66
0F7C
1090
11A4
12B6
13C7
14D6
15E4
16F0
17FA
1902
1A08
1B0C
1C0E
1D0E
1E0C
1F07
2000
20F6
21EA
22DB
23CA
24B5
259E
2684
2767
2847
2923
29FD
2AD3
2BA6
2C75
2D41
2E0A
2ECE
2F90
304D
3107
31BD
326F
331D
33C7
346D
350F
35AD
3646
36DC
376D
37FA
3882
3906
3986
3A01
3A78
3AEA
3B57
3BC0
3C24
3C83
3CDE
3D34
3D85
3DD2
3E19
3E5C
3E9A
3ED3
3F07
3F36
3F61
3F86
3FA6
3FC2
3FD8
3FEA
3FF6
3FFE
4000

// File: hdl/trigTable.sv
module trigTable (
	input logic clk,
	input kinNumPkg::degT angle,
	output kinNumPkg::trigT sine,
	output kinNumPkg::trigT cosine
);
	import kinNumPkg::*;

	localparam int quarterEntries = 91; // 0 to 90 degrees inclusive

	trigT sineRom [quarterEntries];
	degT cosAngle;

	initial
	begin
		$readmemh("hdl/sineQuarter.hex", sineRom);
	end

	// maps any angle onto the first quadrant and restores the sign afterwards
	function automatic trigT foldSine(input degT d);
		degT offset;
		logic negate;
		if (d < 9'd90)
		begin
			offset = d;
			negate = 1'b0;
		end
		else if (d < 9'd180)
		begin
			offset = 9'd180 - d; // second quadrant mirrors the first
			negate = 1'b0;
		end
		else if (d < 9'd270)
		begin
			offset = d - 9'd180;
			negate = 1'b1;
		end
		else
		begin
			offset = 9'd360 - d;
			negate = 1'b1;
		end
		return negate ? -sineRom[offset[6:0]] : sineRom[offset[6:0]];
	endfunction

	// cos(a) is sin(a + 90), kept inside 0 to 359
	always_comb
	begin
		if (angle >= 9'd270)
			cosAngle = angle - 9'd270;
		else
			cosAngle = angle + 9'd90;
	end

	always_ff @(posedge clk)
	begin
		sine <= foldSine(angle);
		cosine <= foldSine(cosAngle);
	end

endmodule

// File: tests/kinematicsTb.sv
`include "kin_macros.svh"

module kinematicsTb;
	timeunit 1ns;
	timeprecision 100ps;

	import kinNumPkg::*;
	import kinFlowPkg::*;

	localparam int waitLimit = 200; // cycles that any single wait may take

	logic clk;
	logic rst;
	logic reqValid;
	angleT th1;
	angleT th2;
	lengthT l1;
	lengthT l2;
	logic reqCredit;
	logic resValid;
	coordT x;
	coordT y;
	logic resCredit;

	int sineTab [91];
	longint expX [$];
	longint expY [$];
	int reqCredits; // credits the sender may still spend
	int creditPulses;
	int results;
	int pendingReturn; // consumed results whose credit has not gone back yet
	int returnDelay;
	int delayCount;
	logic holdCredits;
	int mismatches;
	int timeouts;
	int otherErrors;
	logic [31:0] rngState;

	kinematicsTop kinematicsTop_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		logic [31:0] s;
		s = rngState;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rngState = s;
		return s;
	endfunction

	task automatic buildSineTable();
		int d;
		for (d = 0; d <= 90; d++)
			sineTab[d] = $rtoi(16384.0 * $sin(d * 3.141592653589793 / 180.0) + 0.5);
	endtask

	function automatic int wrapDegrees(input int a);
		int d;
		d = a;
		while (d < 0)
			d += 360;
		while (d >= 360)
			d -= 360;
		return d;
	endfunction

	// quarter table mirrored for the second quadrant and negated for the lower half
	function automatic int tableSine(input int d);
		if (d < 90)
			return sineTab[d];
		else if (d < 180)
			return sineTab[180 - d];
		else if (d < 270)
			return -sineTab[d - 180];
		return -sineTab[360 - d];
	endfunction

	function automatic int tableCosine(input int d);
		return tableSine(wrapDegrees(d + 90));
	endfunction

	always @(negedge clk)
	begin
		if (reqCredit === 1'b1)
		begin
			creditPulses++;
			reqCredits++;
		end
	end

	task automatic checkResult(input longint ex, input longint ey);
		if (longint'(x) != ex || longint'(y) != ey)
		begin
			mismatches++;
			$display("mismatch at %0t: got x=%0d y=%0d, expected x=%0d y=%0d",
				$time, x, y, ex, ey);
		end
	endtask

	always @(negedge clk)
	begin
		if (resValid === 1'b1)
		begin
			results++;
			pendingReturn++;
			if (expX.size() == 0)
			begin
				otherErrors++;
				$display("result at %0t arrived with no request outstanding", $time);
			end
			else
				checkResult(expX.pop_front(), expY.pop_front());
		end
	end

	// receiver gives one credit back per cycle, spaced by returnDelay
	initial
	begin
		forever
		begin
			@(posedge clk);
			#2;
			resCredit = 1'b0;
			if (!holdCredits && pendingReturn > 0)
			begin
				if (delayCount >= returnDelay)
				begin
					resCredit = 1'b1;
					pendingReturn--;
					delayCount = 0;
				end
				else
					delayCount++;
			end
		end
	end

	task automatic sendReq(input int a1, input int a2, input int len1, input int len2);
		int waited;
		int d1;
		int d12;
		waited = 0;
		while (reqCredits == 0 && waited < waitLimit)
		begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (reqCredits == 0)
		begin
			timeouts++;
			$display("timeout at %0t: no request credit came back", $time);
		end
		else
		begin
			d1 = wrapDegrees(a1);
			d12 = wrapDegrees(a1 + a2);
			expX.push_back(longint'(len1) * tableCosine(d1) + longint'(len2) * tableCosine(d12));
			expY.push_back(longint'(len1) * tableSine(d1) + longint'(len2) * tableSine(d12));
			reqValid = 1'b1;
			th1 = angleT'(a1);
			th2 = angleT'(a2);
			l1 = lengthT'(len1);
			l2 = lengthT'(len2);
			reqCredits--;
			@(posedge clk);
			#2;
			reqValid = 1'b0;
		end
	endtask

	task automatic waitResults(input int target);
		int waited;
		waited = 0;
		while (results < target && waited < waitLimit)
		begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (results < target)
		begin
			timeouts++;
			$display("timeout at %0t: only %0d of %0d results arrived", $time, results, target);
		end
	endtask

	task automatic waitCredits();
		int waited;
		waited = 0;
		while (reqCredits < `KIN_QDEPTH && waited < waitLimit)
		begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (reqCredits != `KIN_QDEPTH)
		begin
			timeouts++;
			$display("timeout at %0t: request credits did not all come back", $time);
		end
	endtask

	// the receiver must have handed back every consumed result before credits are held
	task automatic waitReturns();
		int waited;
		waited = 0;
		while (pendingReturn > 0 && waited < waitLimit)
		begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (pendingReturn > 0)
		begin
			timeouts++;
			$display("timeout at %0t: result credits were not all returned", $time);
		end
	endtask

	task automatic resetTest();
		int cycle;
		for (cycle = 0; cycle < 10; cycle++)
		begin
			@(negedge clk);
			if (reqCredit !== 1'b0 || resValid !== 1'b0)
			begin
				mismatches++;
				$display("mismatch at %0t: reqCredit=%b resValid=%b while idle",
					$time, reqCredit, resValid);
			end
		end
		@(posedge clk);
		#2;
	endtask

	task automatic fixedAngleTest();
		int base;
		base = results;
		sendReq(0, 0, 12000, 8000);
		sendReq(90, 0, 12000, 8000);
		sendReq(0, 90, 5000, 32767);
		sendReq(180, -90, 32767, 1);
		sendReq(-90, 45, 777, 20000);
		sendReq(255, 255, 16384, 16383); // sum of 510 wraps to 150
		waitResults(base + 6);
	endtask

	task automatic randomStreamTest();
		int base;
		int pulses;
		logic [31:0] ra;
		logic [31:0] rl;
		base = results;
		pulses = creditPulses;
		repeat (64)
		begin
			ra = nextRandom();
			rl = nextRandom();
			sendReq($signed(ra[8:0]), $signed(ra[17:9]), rl[14:0], rl[29:15]);
		end
		waitResults(base + 64);
		waitCredits();
		if (creditPulses - pulses != 64)
		begin
			mismatches++;
			$display("mismatch at %0t: %0d reqCredit pulses, expected 64",
				$time, creditPulses - pulses);
		end
	endtask

	task automatic backPressureTest();
		int base;
		logic [31:0] ra;
		logic [31:0] rl;
		base = results;
		waitReturns();
		holdCredits = 1'b1;
		repeat (12)
		begin
			ra = nextRandom();
			rl = nextRandom();
			sendReq($signed(ra[8:0]), $signed(ra[17:9]), rl[14:0], rl[29:15]);
		end
		waitResults(base + `KIN_QDEPTH);
		repeat (20) @(posedge clk); // nothing more may leave while credits are held
		#2;
		if (results != base + `KIN_QDEPTH || reqCredits != 0)
		begin
			mismatches++;
			$display("mismatch at %0t: %0d results and %0d request credits under back-pressure",
				$time, results - base, reqCredits);
		end
		returnDelay = 3;
		holdCredits = 1'b0;
		waitResults(base + 12);
		waitCredits();
		returnDelay = 0;
	endtask

	task automatic negativeAngleTest();
		int base;
		logic [31:0] ra;
		base = results;
		repeat (16)
		begin
			ra = nextRandom();
			sendReq(-int'(ra[7:0]) - 1, -int'(ra[15:8]) - 1, 32767, 32767);
		end
		waitResults(base + 16);
		waitCredits();
	endtask

	initial
	begin
		rst = 1'b1;
		reqValid = 1'b0;
		th1 = '0;
		th2 = '0;
		l1 = '0;
		l2 = '0;
		resCredit = 1'b0;
		holdCredits = 1'b0;
		returnDelay = 0;
		delayCount = 0;
		pendingReturn = 0;
		reqCredits = `KIN_QDEPTH;
		creditPulses = 0;
		results = 0;
		mismatches = 0;
		timeouts = 0;
		otherErrors = 0;
		rngState = 32'd16389;
		buildSineTable();
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		resetTest();
		fixedAngleTest();
		randomStreamTest();
		backPressureTest();
		negativeAngleTest();
		$display("checks finished: %0d mismatches, %0d timeouts, %0d other errors",
			mismatches, timeouts, otherErrors);
		if (mismatches + timeouts + otherErrors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: tests/kinematics_properties.sv
`include "kin_macros.svh"

module kinematicsProperties (
	input logic clk,
	input logic rst,
	input logic reqValid,
	input logic reqCredit,
	input logic resValid,
	input logic resCredit,
	input kinFlowPkg::creditT reqCount
);
	timeunit 1ns;
	timeprecision 100ps;

	import kinFlowPkg::*;

	localparam creditT fullCount = creditT'(`KIN_QDEPTH);

	creditT receiverCredits; // room at the receiver, rebuilt from the boundary handshake

	always_ff @(posedge clk)
	begin
		if (rst)
			receiverCredits <= fullCount;
		else
			receiverCredits <= receiverCredits - creditT'(resValid) + creditT'(resCredit);
	end

	// a result may only leave while the receiver still has room for it
	resultNeedsCredit: assert property (@(posedge clk) disable iff (rst)
		resValid |-> receiverCredits != '0)
		else $error("result sent while the output credit count is zero");

	inputNoOverflow: assert property (@(posedge clk) disable iff (rst)
		reqValid |-> reqCount != fullCount) // sender owns a credit for every push
		else $error("request pushed into a full input queue");

	quietAfterReset: assert property (@(posedge clk) rst |=> !reqCredit && !resValid)
		else $error("reqCredit or resValid active in the cycle after reset");

endmodule

bind kinematicsTop kinematicsProperties kinematicsProps (
	.clk(clk), .rst(rst), .reqValid(reqValid), .reqCredit(reqCredit),
	.resValid(resValid), .resCredit(resCredit), .reqCount(reqCount)
);
